/* list.f */
hw/rename_pkg.sv
hw/dispatch_pkg.sv
hw/rename_ifs.sv
hw/inst_queue.sv
hw/free_list.sv
hw/rat.sv
hw/busy_table.sv
hw/dispatcher.sv
hw/rename_dispatch_top.sv
bench/rename_dispatch_assertions.sv
bench/rename_dispatch_tb.sv

/* Makefile */
TOP = rename_dispatch_tb

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "^Simulation passed$$" sim.log

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* bench/rename_dispatch_tb.sv */
// Rename and dispatch testbench driving directed and random stimulus against a reference model
module rename_dispatch_tb;
    import rename_pkg::*;
    import dispatch_pkg::*;

    logic            clk;
    logic            rst;
    logic            inst_push;
    decoded_inst_t   inst_in;
    logic            inst_q_full;
    logic            rs_full;
    logic            rob_full;
    rob_id_t         rob_id_next;
    logic            wb_valid;
    phys_reg_t       wb_phys;
    logic            free_valid;
    phys_reg_t       free_phys;
    logic            dispatch_valid;
    dispatch_entry_t dispatch_entry;

    // Model of RAT, busy bits, free order and the pushed instructions
    phys_reg_t           model_rat [NUM_ARCH];
    logic [NUM_PHYS-1:0] model_busy;
    phys_reg_t           free_q [$];
    phys_reg_t           commit_q [$];
    decoded_inst_t       pend_q [$];
    int cycles = 0;
    int n_push = 0;
    int n_disp = 0;
    int n_tests = 0;
    int errors = 0;
    int errors_mark = 0;

    rename_dispatch_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Expected entry from model state including the same-cycle writeback bypass
    function automatic dispatch_entry_t expected_entry(input decoded_inst_t d, input rob_id_t rid);
        dispatch_entry_t e;
        e.inst      = d;
        e.rob_id    = rid;
        e.phys_rs1  = model_rat[d.rs1];
        e.phys_rs2  = model_rat[d.rs2];
        e.phys_rd   = free_q[0];
        e.rs1_ready = !d.use_rs1 || !model_busy[e.phys_rs1] || (wb_valid && wb_phys == e.phys_rs1);
        e.rs2_ready = !d.use_rs2 || !model_busy[e.phys_rs2] || (wb_valid && wb_phys == e.phys_rs2);
        return e;
    endfunction

    function automatic decoded_inst_t make_inst(input int rd, input int rs1, input int rs2,
                                                input int u1, input int u2);
        decoded_inst_t d;
        d.valid   = 1'b1;
        d.inst    = $urandom;
        d.pc      = $urandom;
        d.rd      = arch_reg_t'(rd);
        d.rs1     = arch_reg_t'(rs1);
        d.rs2     = arch_reg_t'(rs2);
        d.use_rs1 = (u1 != 0);
        d.use_rs2 = (u2 != 0);
        return d;
    endfunction

    task automatic check_field(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        if (got !== want) begin
            $display("Error: %s is %0h, expected %0h", name, got, want);
            errors++;
        end
    endtask

    // Wait for the next falling edge, drop the strobes and present a new ROB id
    task automatic step();
        @(negedge clk);
        rob_id_next = rob_id_t'($urandom);
        inst_push   = 1'b0;
        wb_valid    = 1'b0;
        free_valid  = 1'b0;
    endtask

    task automatic push_inst(input decoded_inst_t d, input bit wait_room);
        step();
        while (wait_room && inst_q_full)
            step();
        inst_in   = d;
        inst_push = 1'b1;
        n_push++;
    endtask

    // Commit returns the oldest retired mapping
    task automatic release_one();
        if (commit_q.size() != 0) begin
            free_valid = 1'b1;
            free_phys  = commit_q.pop_front();
        end
    endtask

    task automatic drain(input bit with_release);
        do begin
            step();
            if (with_release)
                release_one();
        end while (pend_q.size() != 0);
    endtask

    task automatic end_test(input string name);
        if (errors == errors_mark)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, errors - errors_mark);
        errors_mark = errors;
        n_tests++;
    endtask

    // Compare each dispatch and update the model as the tables do at this edge
    always @(posedge clk) begin
        dispatch_entry_t want;
        bit              hit;
        hit = 1'b0;
        cycles++;
        if (!rst) begin
            if (dispatch_valid && pend_q.size() != 0 && free_q.size() != 0) begin
                hit  = 1'b1;
                want = expected_entry(pend_q.pop_front(), rob_id_next);
                check_field("inst", 128'(dispatch_entry.inst), 128'(want.inst));
                check_field("rob_id", 128'(dispatch_entry.rob_id), 128'(want.rob_id));
                check_field("phys_rs1", 128'(dispatch_entry.phys_rs1), 128'(want.phys_rs1));
                check_field("phys_rs2", 128'(dispatch_entry.phys_rs2), 128'(want.phys_rs2));
                check_field("phys_rd", 128'(dispatch_entry.phys_rd), 128'(want.phys_rd));
                check_field("rs1_ready", 128'(dispatch_entry.rs1_ready), 128'(want.rs1_ready));
                check_field("rs2_ready", 128'(dispatch_entry.rs2_ready), 128'(want.rs2_ready));
                n_disp++;
            end else if (dispatch_valid) begin
                $display("Extra dispatch at cycle %0d with nothing pending or no free register",
                         cycles);
                errors++;
            end
            if (wb_valid)
                model_busy[wb_phys] = 1'b0;
            if (hit) begin
                // x0 hands back its own register and other destinations their old mapping
                commit_q.push_back(want.inst.rd != '0 ? model_rat[want.inst.rd] : want.phys_rd);
                if (want.inst.rd != '0) begin
                    model_rat[want.inst.rd] = want.phys_rd;
                    model_busy[want.phys_rd] = 1'b1;
                end
                void'(free_q.pop_front());
            end
            if (free_valid)
                free_q.push_back(free_phys);
            if (inst_push && !inst_q_full)
                pend_q.push_back(inst_in);
        end
    end

    // Limit grows with every push attempt
    initial begin
        while (cycles <= 20 * n_push + 200)
            @(negedge clk);
        $display("Timeout after %0d cycles, %0d instructions never dispatched",
                 cycles, pend_q.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int        i;
        int        need;
        phys_reg_t p;
        void'($urandom(32'h0ca7_4510));
        rst         = 1'b1;
        inst_push   = 1'b0;
        inst_in     = '0;
        rs_full     = 1'b0;
        rob_full    = 1'b0;
        rob_id_next = '0;
        wb_valid    = 1'b0;
        wb_phys     = '0;
        free_valid  = 1'b0;
        free_phys   = '0;
        for (i = 0; i < NUM_ARCH; i++)
            model_rat[i] = phys_reg_t'(i);
        for (i = 0; i < NUM_FREE; i++)
            free_q.push_back(phys_reg_t'(NUM_ARCH + i));
        model_busy = '0;
        repeat (3) step();
        rst = 1'b0;

        // Identity mappings with destinations from 32 upward
        push_inst(make_inst(5, 1, 2, 1, 1), 1'b1);
        push_inst(make_inst(6, 3, 4, 1, 1), 1'b1);
        push_inst(make_inst(7, 30, 31, 1, 1), 1'b1);
        drain(1'b0);
        end_test("reset_mapping");

        // Producer, pending reader with an immediate, x0 destination, x0 source
        push_inst(make_inst(8, 1, 2, 1, 1), 1'b1);
        push_inst(make_inst(9, 8, 8, 1, 0), 1'b1);
        push_inst(make_inst(0, 9, 8, 1, 1), 1'b1);
        push_inst(make_inst(10, 0, 9, 1, 1), 1'b1);
        drain(1'b0);
        end_test("dependency_chain");

        push_inst(make_inst(12, 1, 2, 1, 1), 1'b1);
        drain(1'b0);
        p = model_rat[12];
        // Reader's valid cycle starts two falling edges after its push
        push_inst(make_inst(13, 12, 3, 1, 1), 1'b1);
        step();
        step();
        wb_valid = 1'b1;
        wb_phys  = p;
        drain(1'b0);
        push_inst(make_inst(14, 12, 13, 1, 1), 1'b1);
        drain(1'b0);
        end_test("writeback");

        // Fill the queue under back-pressure so the last two pushes are dropped
        rs_full = 1'b1;
        need    = n_disp;
        for (i = 0; i < 10; i++)
            push_inst(make_inst(16 + i, i, i + 1, 1, 1), 1'b0);
        repeat (4) step();
        rs_full  = 1'b0;
        rob_full = 1'b1;
        repeat (4) step();
        if (n_disp != need) begin
            $display("Dispatch happened while a full flag was high");
            errors++;
        end
        if (pend_q.size() != IQ_DEPTH || !inst_q_full) begin
            $display("Queue holds %0d instructions and is not reported full", pend_q.size());
            errors++;
        end
        rob_full = 1'b0;
        drain(1'b0);
        end_test("back_pressure");

        // Use up the free list and hand back three retired registers afterwards
        need = free_q.size() + 2;
        for (i = 0; i < need; i++)
            push_inst(make_inst(1 + i % 31, i % 32, 31 - i % 32, 1, 1), 1'b1);
        while (free_q.size() != 0)
            step();
        // Two instructions wait in the queue with no register to take
        repeat (6) begin
            step();
            if (dispatch_valid) begin
                $display("Dispatch did not stop with an empty free list");
                errors++;
            end
        end
        repeat (3) begin
            step();
            release_one();
        end
        drain(1'b0);
        end_test("free_list_exhaustion");

        // Random instructions, full flags, writebacks and releases
        for (i = 0; i < 300; i++) begin
            step();
            rs_full  = ($urandom % 8) == 0;
            rob_full = ($urandom % 8) == 0;
            wb_valid = ($urandom % 3) == 0;
            wb_phys  = model_rat[arch_reg_t'($urandom % 8)];
            if ($urandom % 3 == 0)
                release_one();
            if ($urandom % 2 == 0) begin
                inst_in   = make_inst($urandom % 8, $urandom % 8, $urandom % 8,
                                      $urandom % 2, $urandom % 2);
                inst_push = 1'b1;
                n_push++;
            end
        end
        rs_full  = 1'b0;
        rob_full = 1'b0;
        drain(1'b1);
        end_test("random_stream");

        $display("Tests %0d, dispatches checked %0d, errors %0d", n_tests, n_disp, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : rename_dispatch_tb

/* bench/rename_dispatch_assertions.sv */
// Dispatcher assertions: reset state, pop conditions, x0 rename and dispatch timing
module rename_dispatch_assertions (
    input logic                  clk,
    input logic                  rst,
    input logic                  rs_full,
    input logic                  rob_full,
    input logic                  iq_empty,
    input logic                  fl_empty,
    input logic                  pop,
    input logic                  rename_en,
    input rename_pkg::arch_reg_t rd,
    input logic                  dispatch_valid
);
    // Nothing is in flight right after reset
    valid_low_after_reset: assert property (@(posedge clk) rst |=> !dispatch_valid)
        else $error("dispatch_valid high in the cycle after reset");
    // Joint pop needs data in both FIFOs and room downstream
    pop_allowed: assert property (@(posedge clk) disable iff (rst)
        pop |-> !iq_empty && !fl_empty && !rs_full && !rob_full)
        else $error("pop while a FIFO is empty or a full flag is high");
    no_x0_rename: assert property (@(posedge clk) disable iff (rst) rename_en |-> rd != '0)
        else $error("rename requested for x0");
    // Valid is the pop delayed by one cycle
    valid_follows_pop: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid == $past(pop))
        else $error("dispatch_valid does not follow pop by one cycle");
endmodule : rename_dispatch_assertions

bind dispatcher rename_dispatch_assertions i_assertions (
    .clk            (clk),
    .rst            (rst),
    .rs_full        (rs_full),
    .rob_full       (rob_full),
    .iq_empty       (iq_empty),
    .fl_empty       (fl_empty),
    .pop            (pop),
    .rename_en      (rd_write),
    .rd             (inst.rd),
    .dispatch_valid (dispatch_valid)
);

/* hw/rename_dispatch_top.sv */
// Rename and dispatch stage top: instruction queue, free list, RAT, busy table, dispatcher
module rename_dispatch_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inst_push,
    input  dispatch_pkg::decoded_inst_t   inst_in,
    output logic                          inst_q_full,
    input  logic                          rs_full,
    input  logic                          rob_full,
    input  rename_pkg::rob_id_t           rob_id_next,
    input  logic                          wb_valid,
    input  rename_pkg::phys_reg_t         wb_phys,
    input  logic                          free_valid,
    input  rename_pkg::phys_reg_t         free_phys,
    output logic                          dispatch_valid,
    output dispatch_pkg::dispatch_entry_t dispatch_entry
);
    import rename_pkg::*;
    import dispatch_pkg::*;

    // One pop strobe drives both FIFOs
    logic          iq_pop;
    logic          iq_empty;
    decoded_inst_t iq_head;
    logic          fl_empty;
    phys_reg_t     fl_head;

    rename_if ren_bus ();
    ready_if  rdy_bus ();

    inst_queue i_inst_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (inst_push),
        .push_data (inst_in),
        .pop       (iq_pop),
        .head      (iq_head),
        .empty     (iq_empty),
        .full      (inst_q_full)
    );

    free_list i_free_list (
        .clk         (clk),
        .rst         (rst),
        .pop         (iq_pop),
        .head        (fl_head),
        .empty       (fl_empty),
        .release_en  (free_valid),
        .release_reg (free_phys)
    );

    rat i_rat (
        .clk (clk),
        .rst (rst),
        .ren (ren_bus)
    );

    busy_table i_busy_table (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy_bus),
        .wb_valid (wb_valid),
        .wb_phys  (wb_phys)
    );

    dispatcher i_dispatcher (
        .clk            (clk),
        .rst            (rst),
        .rs_full        (rs_full),
        .rob_full       (rob_full),
        .iq_empty       (iq_empty),
        .fl_empty       (fl_empty),
        .pop            (iq_pop),
        .inst           (iq_head),
        .free_rd        (fl_head),
        .rob_id_next    (rob_id_next),
        .ren            (ren_bus),
        .rdy            (rdy_bus),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry)
    );

endmodule : rename_dispatch_top

/* hw/dispatcher.sv */
// Dispatcher: pops queue and free list together, renames, builds the dispatch entry
module dispatcher (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rs_full,
    input  logic                          rob_full,
    input  logic                          iq_empty,
    input  logic                          fl_empty,
    output logic                          pop,
    input  dispatch_pkg::decoded_inst_t   inst,
    input  rename_pkg::phys_reg_t         free_rd,
    input  rename_pkg::rob_id_t           rob_id_next,
    rename_if.disp                        ren,
    ready_if.disp                         rdy,
    output logic                          dispatch_valid,
    output dispatch_pkg::dispatch_entry_t dispatch_entry
);

    logic rd_write;

    // Pop only when both queues have data and both consumers have room
    assign pop = !rs_full && !rob_full && !iq_empty && !fl_empty;

    // Popped heads are in their registers one cycle later
    always_ff @(posedge clk) begin
        if (rst)
            dispatch_valid <= 1'b0;
        else
            dispatch_valid <= pop;
    end

    // x0 keeps its mapping and is never marked busy
    assign rd_write = dispatch_valid && (inst.rd != '0);

    // RAT lookup and destination rename
    assign ren.isa_rs1   = inst.rs1;
    assign ren.isa_rs2   = inst.rs2;
    assign ren.isa_rd    = inst.rd;
    assign ren.new_rd    = free_rd;
    assign ren.rename_en = rd_write;

    // Readiness of the renamed sources
    assign rdy.query_rs1 = ren.rat_rs1;
    assign rdy.query_rs2 = ren.rat_rs2;
    assign rdy.alloc_rd  = free_rd;
    assign rdy.alloc_en  = rd_write;

    always_comb begin
        dispatch_entry.inst     = inst;
        dispatch_entry.rob_id   = rob_id_next;
        dispatch_entry.phys_rs1 = ren.rat_rs1;
        dispatch_entry.phys_rs2 = ren.rat_rs2;
        // Popped register goes out even for x0, the ROB frees it at commit
        dispatch_entry.phys_rd  = free_rd;
        // Immediate or PC operands need no producer
        dispatch_entry.rs1_ready = !inst.use_rs1 || rdy.rs1_ready;
        dispatch_entry.rs2_ready = !inst.use_rs2 || rdy.rs2_ready;
    end

endmodule : dispatcher

/* hw/busy_table.sv */
// Busy table: pending bit per physical register, set at dispatch, cleared at writeback
module busy_table (
    input logic                  clk,
    input logic                  rst,
    ready_if.tbl                 rdy,
    input logic                  wb_valid,
    input rename_pkg::phys_reg_t wb_phys
);
    import rename_pkg::*;

    logic [NUM_PHYS-1:0] busy;

    // Writeback in the same cycle counts as ready
    assign rdy.rs1_ready = !busy[rdy.query_rs1] || (wb_valid && wb_phys == rdy.query_rs1);
    assign rdy.rs2_ready = !busy[rdy.query_rs2] || (wb_valid && wb_phys == rdy.query_rs2);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_valid)
                busy[wb_phys] <= 1'b0;
            // New destination is pending until its own writeback
            if (rdy.alloc_en)
                busy[rdy.alloc_rd] <= 1'b1;
        end
    end

endmodule : busy_table

/* hw/rat.sv */
// Register alias table: maps each ISA register to its newest physical register
module rat (
    input logic  clk,
    input logic  rst,
    rename_if.tbl ren
);
    import rename_pkg::*;

    phys_reg_t map [NUM_ARCH];

    // Source lookups are combinational
    assign ren.rat_rs1 = map[ren.isa_rs1];
    assign ren.rat_rs2 = map[ren.isa_rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, x0 stays on physical register zero
            for (int i = 0; i < NUM_ARCH; i++)
                map[i] <= phys_reg_t'(i);
        end else if (ren.rename_en && ren.isa_rd != '0) begin
            map[ren.isa_rd] <= ren.new_rd;
        end
    end

endmodule : rat

/* hw/free_list.sv */
// Free list: FIFO of unmapped physical registers, preloaded at reset, refilled at commit
module free_list (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pop,
    output rename_pkg::phys_reg_t head,
    output logic                  empty,
    input  logic                  release_en,
    input  rename_pkg::phys_reg_t release_reg
);
    import rename_pkg::*;

    typedef logic [$clog2(NUM_FREE)-1:0] fl_ptr_t;
    typedef logic [$clog2(NUM_FREE):0]   fl_cnt_t;

    phys_reg_t mem [NUM_FREE];
    fl_ptr_t   wr_ptr;
    fl_ptr_t   rd_ptr;
    fl_cnt_t   count;
    logic      do_pop;

    assign empty  = (count == '0);
    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Registers above the ISA range start out free, lowest first
            for (int i = 0; i < NUM_FREE; i++)
                mem[i] <= phys_reg_t'(NUM_ARCH + i);
            // Buffer is full so the write pointer has wrapped to zero
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= fl_cnt_t'(NUM_FREE);
        end else begin
            // Commit order is kept by appending at the tail
            if (release_en) begin
                mem[wr_ptr] <= release_reg;
                wr_ptr      <= wr_ptr + 1'b1;
            end
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (release_en && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !release_en)
                count <= count - 1'b1;
        end
    end

    // Head register loads with the instruction queue pop
    always_ff @(posedge clk) begin
        if (do_pop)
            head <= mem[rd_ptr];
    end

endmodule : free_list

/* hw/inst_queue.sv */
// Instruction queue: circular FIFO of decoded instructions with a registered head
module inst_queue (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  dispatch_pkg::decoded_inst_t push_data,
    input  logic                        pop,
    output dispatch_pkg::decoded_inst_t head,
    output logic                        empty,
    output logic                        full
);
    import dispatch_pkg::*;

    typedef logic [$clog2(IQ_DEPTH)-1:0] iq_ptr_t;
    typedef logic [$clog2(IQ_DEPTH):0]   iq_cnt_t;

    decoded_inst_t mem [IQ_DEPTH];
    iq_ptr_t       wr_ptr;
    iq_ptr_t       rd_ptr;
    iq_cnt_t       count;
    logic          do_push;
    logic          do_pop;

    // Pushes into a full queue are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == iq_cnt_t'(IQ_DEPTH));

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // Storage and head register
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
        // Oldest entry moves to the head on a pop
        if (do_pop)
            head <= mem[rd_ptr];
    end

endmodule : inst_queue

/* hw/rename_ifs.sv */
// Rename and readiness interfaces between the dispatcher and its lookup tables

// RAT lookup of both sources and update of the destination mapping
interface rename_if;
    import rename_pkg::*;

    arch_reg_t isa_rs1;
    arch_reg_t isa_rs2;
    arch_reg_t isa_rd;
    phys_reg_t rat_rs1;
    phys_reg_t rat_rs2;
    phys_reg_t new_rd;
    logic      rename_en;

    modport disp (output isa_rs1, isa_rs2, isa_rd, new_rd, rename_en,
                  input  rat_rs1, rat_rs2);
    modport tbl  (input  isa_rs1, isa_rs2, isa_rd, new_rd, rename_en,
                  output rat_rs1, rat_rs2);
endinterface : rename_if

// Busy table query of both sources and busy mark of the new destination
interface ready_if;
    import rename_pkg::*;

    phys_reg_t query_rs1;
    phys_reg_t query_rs2;
    logic      rs1_ready;
    logic      rs2_ready;
    phys_reg_t alloc_rd;
    logic      alloc_en;

    modport disp (output query_rs1, query_rs2, alloc_rd, alloc_en,
                  input  rs1_ready, rs2_ready);
    modport tbl  (input  query_rs1, query_rs2, alloc_rd, alloc_en,
                  output rs1_ready, rs2_ready);
endinterface : ready_if

/* hw/dispatch_pkg.sv */
// Dispatch package: decoded instruction and dispatch entry layouts, queue depth
package dispatch_pkg;

    // Decoded instructions waiting to be renamed
    localparam int IQ_DEPTH = 8;

    // One decoded instruction as it leaves decode
    typedef struct packed {
        logic                  valid;
        logic [31:0]           inst;
        logic [31:0]           pc;
        rename_pkg::arch_reg_t rs1;
        rename_pkg::arch_reg_t rs2;
        rename_pkg::arch_reg_t rd;
        // Low when the operand is an immediate or the PC
        logic                  use_rs1;
        logic                  use_rs2;
    } decoded_inst_t;

    // Renamed instruction for the reservation station and the ROB
    typedef struct packed {
        decoded_inst_t         inst;
        rename_pkg::rob_id_t   rob_id;
        rename_pkg::phys_reg_t phys_rs1;
        rename_pkg::phys_reg_t phys_rs2;
        rename_pkg::phys_reg_t phys_rd;
        logic                  rs1_ready;
        logic                  rs2_ready;
    } dispatch_entry_t;

endpackage : dispatch_pkg

/* hw/rename_pkg.sv */
// Register naming package: architectural, physical and ROB index types and sizes
package rename_pkg;

    // Register file sizes
    localparam int NUM_ARCH = 32;
    localparam int NUM_PHYS = 64;

    // Free list holds every physical register not mapped at reset
    localparam int NUM_FREE = NUM_PHYS - NUM_ARCH;

    // Reorder buffer slots
    localparam int ROB_DEPTH = 8;

    // ISA register index, x0 to x31
    typedef logic [$clog2(NUM_ARCH)-1:0] arch_reg_t;

    // Physical register index, twice the ISA space
    typedef logic [$clog2(NUM_PHYS)-1:0] phys_reg_t;

    // Slot in the reorder buffer
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_id_t;

endpackage : rename_pkg
